//--- list.f
source/fetch_pkg.sv
source/icache_mem.sv
source/icache.sv
source/fetch_pc.sv
source/icache_refill.sv
source/fetch_top.sv
verif/fetch_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the fetch front end testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module fetch_tb -f list.f

./obj_dir/Vfetch_tb | tee sim.log

# a missing pass line makes grep fail, and set -e turns that into the exit status
grep -q "^TEST RESULT: PASS$" sim.log
echo "simulation passed"

//--- source/fetch_pc.sv
/* fetch_pc
   PC register and next-PC choice: redirect, then replay, then static
   prediction of the word just fetched, then fall-through */
`timescale 1ns/1ps

module fetch_pc (
  input                                     clk_i,
  input                                     reset_i,
  input                                     stall_i,
  input                                     replay_v_i,
  input        [fetch_pkg::pc_width_lp-1:0] replay_pc_i,
  input                                     redirect_v_i,
  input        [fetch_pkg::pc_width_lp-1:0] redirect_pc_i,
  input                                     hit_i,
  input  fetch_pkg::fetch_out_s             fetch_i,
  output logic                              rd_v_o,
  output logic [fetch_pkg::pc_width_lp-1:0] rd_pc_o
);
  import fetch_pkg::*;

  // fall-through address, last issued PC plus one
  logic [pc_width_lp-1:0] pc_r;
  logic                   rd_v_r;
  logic                   redirect_pend_r;
  logic                   miss_seen;
  logic                   busy;
  logic                   is_branch;
  logic                   is_jump;
  logic                   taken;

  // read went out last cycle but did not hit, refill starts next edge
  assign miss_seen = rd_v_r & ~hit_i;
  assign busy      = stall_i | miss_seen;

  // static rule, JAL and JALR always, branch only when backward
  assign is_branch = fetch_i.instr.op == op_branch_lp;
  assign is_jump   = (fetch_i.instr.op == op_jal_lp) | (fetch_i.instr.op == op_jalr_lp);
  assign taken     = is_jump | (is_branch & fetch_i.instr.funct7[6]);

  always_comb begin
    if (redirect_v_i) begin
      rd_pc_o = redirect_pc_i;
    end else if (replay_v_i) begin
      // a redirect seen during refill replaces the replayed PC
      rd_pc_o = redirect_pend_r ? pc_r : replay_pc_i;
    end else if (hit_i & taken) begin
      rd_pc_o = fetch_i.pred_addr;
    end else if (hit_i) begin
      rd_pc_o = fetch_i.pc + 1'b1;
    end else begin
      rd_pc_o = pc_r;
    end
  end

  // replay is the one read allowed while the refill holds stall
  assign rd_v_o = ~busy | replay_v_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_r            <= '0;
      rd_v_r          <= 1'b0;
      redirect_pend_r <= 1'b0;
    end else begin
      rd_v_r <= rd_v_o;
      if (rd_v_o) begin
        pc_r            <= rd_pc_o + 1'b1;
        redirect_pend_r <= 1'b0;
      end else if (redirect_v_i) begin
        // park the target until the replay slot
        pc_r            <= redirect_pc_i;
        redirect_pend_r <= 1'b1;
      end
    end
  end

endmodule

//--- source/fetch_pkg.sv
/* fetch_pkg
   widths, RV32 opcodes and packed records shared by the instruction fetch
   front end: PC unit, instruction cache and refill engine */
package fetch_pkg;

  // RV32 word and address space
  localparam int instr_width_lp     = 32;
  localparam int byte_addr_width_lp = instr_width_lp;

  // cache geometry
  localparam int icache_tag_width_lp  = 6;
  localparam int icache_entries_lp    = 16;
  localparam int icache_addr_width_lp = $clog2(icache_entries_lp);

  // word address PC, tag above index
  localparam int pc_width_lp = icache_tag_width_lp + icache_addr_width_lp;

  // immediate widths, sign bit not counted
  localparam int bimm_width_lp = 12;
  localparam int jimm_width_lp = 20;

  // byte-address split for the write-time target adder
  localparam int bpc_low_width_lp  = bimm_width_lp + 1;
  localparam int jpc_low_width_lp  = jimm_width_lp + 1;
  localparam int bpc_high_width_lp = byte_addr_width_lp - bpc_low_width_lp;
  localparam int jpc_high_width_lp = byte_addr_width_lp - jpc_low_width_lp;

  // major opcodes
  localparam logic [6:0] op_branch_lp = 7'b1100011;
  localparam logic [6:0] op_jal_lp    = 7'b1101111;
  localparam logic [6:0] op_jalr_lp   = 7'b1100111;

  // R-type field layout, other formats reuse the same bits
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] op;
  } instr_s;

  // one cache line, precomputed sign and carry kept beside the tag
  typedef struct packed {
    logic                           lower_sign;
    logic                           lower_cout;
    logic [icache_tag_width_lp-1:0] tag;
    instr_s                         instr;
  } icache_entry_s;

  // refill write into the cache
  typedef struct packed {
    logic [pc_width_lp-1:0] pc;
    instr_s                 instr;
  } refill_wr_s;

  // fetched word with its PC and predicted next PC
  typedef struct packed {
    logic [pc_width_lp-1:0] pc;
    instr_s                 instr;
    logic [pc_width_lp-1:0] pred_addr;
  } fetch_out_s;

endpackage

//--- source/fetch_top.sv
/* fetch_top
   instruction fetch front end; PC unit, direct-mapped cache with
   precomputed targets, and the single-word refill engine */
`timescale 1ns/1ps

module fetch_top (
  input                                        clk_i,
  input                                        reset_i,
  input                                        redirect_v_i,
  input        [fetch_pkg::pc_width_lp-1:0]    redirect_pc_i,
  input        [fetch_pkg::pc_width_lp-1:0]    jalr_pred_i,
  output logic                                 mem_v_o,
  output logic [fetch_pkg::pc_width_lp-1:0]    mem_addr_o,
  input        [fetch_pkg::instr_width_lp-1:0] mem_data_i,
  output logic                                 fetch_v_o,
  output fetch_pkg::fetch_out_s                fetch_o
);
  import fetch_pkg::*;

  logic                   rd_v;
  logic [pc_width_lp-1:0] rd_pc;
  logic                   miss;
  logic                   stall;
  logic                   replay_v;
  logic [pc_width_lp-1:0] replay_pc;
  logic                   wr_v;
  refill_wr_s             wr;

  // cache hit doubles as the fetch valid
  fetch_pc pc_unit (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .stall_i      (stall),
    .replay_v_i   (replay_v),
    .replay_pc_i  (replay_pc),
    .redirect_v_i (redirect_v_i),
    .redirect_pc_i(redirect_pc_i),
    .hit_i        (fetch_v_o),
    .fetch_i      (fetch_o),
    .rd_v_o       (rd_v),
    .rd_pc_o      (rd_pc)
  );

  icache cache (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .rd_v_i     (rd_v),
    .rd_pc_i    (rd_pc),
    .jalr_pred_i(jalr_pred_i),
    .wr_v_i     (wr_v),
    .wr_i       (wr),
    .fetch_o    (fetch_o),
    .hit_o      (fetch_v_o),
    .miss_o     (miss)
  );

  // missed PC is the cache's registered read PC
  icache_refill refill (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .miss_i     (miss),
    .miss_pc_i  (fetch_o.pc),
    .mem_v_o    (mem_v_o),
    .mem_addr_o (mem_addr_o),
    .mem_data_i (mem_data_i),
    .wr_v_o     (wr_v),
    .wr_o       (wr),
    .replay_v_o (replay_v),
    .replay_pc_o(replay_pc),
    .stall_o    (stall)
  );

endmodule

//--- source/icache.sv
/* icache
   direct-mapped instruction cache; branch and JAL words get their target
   low part added in on write, and the read side only bumps the high part
   by the stored sign and carry before choosing the predicted next PC */
`timescale 1ns/1ps

module icache (
  input                                     clk_i,
  input                                     reset_i,
  input                                     rd_v_i,
  input        [fetch_pkg::pc_width_lp-1:0] rd_pc_i,
  input        [fetch_pkg::pc_width_lp-1:0] jalr_pred_i,
  input                                     wr_v_i,
  input  fetch_pkg::refill_wr_s             wr_i,
  output fetch_pkg::fetch_out_s             fetch_o,
  output logic                              hit_o,
  output logic                              miss_o
);
  import fetch_pkg::*;

  // B-type immediate as a 13-bit byte offset
  function automatic logic [bpc_low_width_lp-1:0] bimm_get(
    input logic [instr_width_lp-1:0] w
  );
    return {w[31], w[7], w[30:25], w[11:8], 1'b0};
  endfunction

  // J-type immediate as a 21-bit byte offset
  function automatic logic [jpc_low_width_lp-1:0] jimm_get(
    input logic [instr_width_lp-1:0] w
  );
    return {w[31], w[19:12], w[20], w[30:21], 1'b0};
  endfunction

  // bit 0 of the sum is always zero, so it is dropped
  function automatic logic [instr_width_lp-1:0] bimm_put(
    input logic [instr_width_lp-1:0]   w,
    input logic [bpc_low_width_lp-1:0] s
  );
    logic [instr_width_lp-1:0] r;
    r        = w;
    r[31]    = s[12];
    r[7]     = s[11];
    r[30:25] = s[10:5];
    r[11:8]  = s[4:1];
    return r;
  endfunction

  function automatic logic [instr_width_lp-1:0] jimm_put(
    input logic [instr_width_lp-1:0]   w,
    input logic [jpc_low_width_lp-1:0] s
  );
    logic [instr_width_lp-1:0] r;
    r        = w;
    r[31]    = s[20];
    r[19:12] = s[19:12];
    r[20]    = s[11];
    r[30:21] = s[10:1];
    return r;
  endfunction

  logic [icache_addr_width_lp-1:0] wr_idx;
  logic [icache_tag_width_lp-1:0]  wr_tag;
  logic [byte_addr_width_lp-1:0]   wr_pc_byte;
  logic [bpc_low_width_lp-1:0]     wr_bimm;
  logic [bpc_low_width_lp-1:0]     wr_bsum;
  logic                            wr_bcout;
  logic [jpc_low_width_lp-1:0]     wr_jimm;
  logic [jpc_low_width_lp-1:0]     wr_jsum;
  logic                            wr_jcout;
  icache_entry_s                   entry_in;
  icache_entry_s                   rd_entry;
  logic [icache_addr_width_lp-1:0] mem_addr;
  logic [icache_entries_lp-1:0]    valid_r;
  logic                            rd_v_r;
  logic                            rd_valid_r;
  logic [pc_width_lp-1:0]          pc_r;
  logic [byte_addr_width_lp-1:0]   pc_r_byte;
  logic                            keep_high;
  logic                            high_up;
  logic [bpc_high_width_lp-1:0]    bpc_high;
  logic [bpc_high_width_lp-1:0]    bpc_high_out;
  logic [jpc_high_width_lp-1:0]    jpc_high;
  logic [jpc_high_width_lp-1:0]    jpc_high_out;
  logic [byte_addr_width_lp-1:0]   btarget;
  logic [byte_addr_width_lp-1:0]   jtarget;
  logic [pc_width_lp-1:0]          pred_addr;
  instr_s                          out_instr;
  logic                            rd_is_branch;
  logic                            rd_is_jal;

  // write PC split and zero-extended byte address
  assign wr_idx     = wr_i.pc[icache_addr_width_lp-1:0];
  assign wr_tag     = wr_i.pc[icache_addr_width_lp +: icache_tag_width_lp];
  assign wr_pc_byte = byte_addr_width_lp'({wr_i.pc, 2'b00});

  // low-part adders, carry kept for the read side
  assign wr_bimm = bimm_get(wr_i.instr);
  assign wr_jimm = jimm_get(wr_i.instr);
  assign {wr_bcout, wr_bsum} = {1'b0, wr_bimm} + {1'b0, wr_pc_byte[bpc_low_width_lp-1:0]};
  assign {wr_jcout, wr_jsum} = {1'b0, wr_jimm} + {1'b0, wr_pc_byte[jpc_low_width_lp-1:0]};

  // sum replaces the immediate, other opcodes pass unchanged
  always_comb begin
    entry_in.tag = wr_tag;
    if (wr_i.instr.op == op_branch_lp) begin
      entry_in.instr      = bimm_put(wr_i.instr, wr_bsum);
      entry_in.lower_sign = wr_bimm[bpc_low_width_lp-1];
      entry_in.lower_cout = wr_bcout;
    end else if (wr_i.instr.op == op_jal_lp) begin
      entry_in.instr      = jimm_put(wr_i.instr, wr_jsum);
      entry_in.lower_sign = wr_jimm[jpc_low_width_lp-1];
      entry_in.lower_cout = wr_jcout;
    end else begin
      entry_in.instr      = wr_i.instr;
      entry_in.lower_sign = 1'b0;
      entry_in.lower_cout = 1'b0;
    end
  end

  // refill write takes the port over the read
  assign mem_addr = wr_v_i ? wr_idx : rd_pc_i[icache_addr_width_lp-1:0];

  icache_mem mem (
    .clk_i  (clk_i),
    .reset_i(reset_i),
    .v_i    (wr_v_i | rd_v_i),
    .w_i    (wr_v_i),
    .addr_i (mem_addr),
    .data_i (entry_in),
    .data_o (rd_entry)
  );

  // read PC and valid bit travel with the array read
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      valid_r    <= '0;
      rd_v_r     <= 1'b0;
      rd_valid_r <= 1'b0;
      pc_r       <= '0;
    end else begin
      rd_v_r <= rd_v_i;
      if (wr_v_i) begin
        valid_r[wr_idx] <= 1'b1;
      end
      if (rd_v_i) begin
        pc_r       <= rd_pc_i;
        rd_valid_r <= valid_r[rd_pc_i[icache_addr_width_lp-1:0]];
      end
    end
  end

  // merge in the 32-bit byte space, then cut to the word PC
  assign pc_r_byte = byte_addr_width_lp'({pc_r, 2'b00});
  assign bpc_high  = pc_r_byte[byte_addr_width_lp-1 -: bpc_high_width_lp];
  assign jpc_high  = pc_r_byte[byte_addr_width_lp-1 -: jpc_high_width_lp];

  // sign == cout keeps the high part, 0/1 steps up, 1/0 steps down
  assign keep_high = ~(rd_entry.lower_sign ^ rd_entry.lower_cout);
  assign high_up   = ~rd_entry.lower_sign & rd_entry.lower_cout;

  always_comb begin
    if (keep_high) begin
      bpc_high_out = bpc_high;
      jpc_high_out = jpc_high;
    end else if (high_up) begin
      bpc_high_out = bpc_high + 1'b1;
      jpc_high_out = jpc_high + 1'b1;
    end else begin
      bpc_high_out = bpc_high - 1'b1;
      jpc_high_out = jpc_high - 1'b1;
    end
  end

  assign btarget = {bpc_high_out, bimm_get(rd_entry.instr)};
  assign jtarget = {jpc_high_out, jimm_get(rd_entry.instr)};

  assign rd_is_branch = rd_entry.instr.op == op_branch_lp;
  assign rd_is_jal    = rd_entry.instr.op == op_jal_lp;

  always_comb begin
    if (rd_is_jal) begin
      pred_addr = jtarget[2 +: pc_width_lp];
    end else if (rd_entry.instr.op == op_jalr_lp) begin
      pred_addr = jalr_pred_i;
    end else begin
      pred_addr = btarget[2 +: pc_width_lp];
    end
  end

  // bit 31 shows the original immediate sign again, used by static prediction
  always_comb begin
    out_instr = rd_entry.instr;
    if (rd_is_branch | rd_is_jal) begin
      out_instr.funct7[6] = rd_entry.lower_sign;
    end
  end

  assign fetch_o = '{pc: pc_r, instr: out_instr, pred_addr: pred_addr};

  // an invalid entry decides the miss before its tag is looked at
  assign miss_o = rd_v_r & (~rd_valid_r | (rd_entry.tag != pc_r[pc_width_lp-1 -: icache_tag_width_lp]));
  assign hit_o  = rd_v_r & ~miss_o;

  // refill only writes while fetch is frozen
  a_no_rd_wr: assert property (
    @(posedge clk_i) disable iff (reset_i)
    !(wr_v_i && rd_v_i)
  ) else $error("icache: read and write in the same cycle");

  a_miss_known: assert property (
    @(posedge clk_i) disable iff (reset_i)
    !$isunknown(miss_o)
  ) else $error("icache: miss level unknown");

endmodule

//--- source/icache_mem.sv
/* icache_mem
   single-port synchronous entry array; a read loads the output register,
   which keeps its word through writes and idle cycles */
`timescale 1ns/1ps

module icache_mem (
  input                                              clk_i,
  input                                              reset_i,
  input                                              v_i,
  input                                              w_i,
  input        [fetch_pkg::icache_addr_width_lp-1:0] addr_i,
  input  fetch_pkg::icache_entry_s                   data_i,
  output fetch_pkg::icache_entry_s                   data_o
);
  import fetch_pkg::*;

  icache_entry_s mem_r [icache_entries_lp];
  icache_entry_s data_r;

  // write wins, read data only moves on a read
  always_ff @(posedge clk_i) begin
    if (v_i & w_i) begin
      mem_r[addr_i] <= data_i;
    end else if (v_i) begin
      data_r <= mem_r[addr_i];
    end
  end

  // held word lets a stalled fetch see the same entry
  assign data_o = data_r;

  // index must be known on any access
  a_addr_known: assert property (
    @(posedge clk_i) disable iff (reset_i)
    v_i |-> !$isunknown(addr_i)
  ) else $error("icache_mem: unknown address on access");

endmodule

//--- source/icache_refill.sv
/* icache_refill
   miss handler; latches the missing PC, reads one word from backing
   memory with fixed one-cycle latency, writes it and asks for a replay */
`timescale 1ns/1ps

module icache_refill (
  input                                        clk_i,
  input                                        reset_i,
  input                                        miss_i,
  input        [fetch_pkg::pc_width_lp-1:0]    miss_pc_i,
  output logic                                 mem_v_o,
  output logic [fetch_pkg::pc_width_lp-1:0]    mem_addr_o,
  input        [fetch_pkg::instr_width_lp-1:0] mem_data_i,
  output logic                                 wr_v_o,
  output fetch_pkg::refill_wr_s                wr_o,
  output logic                                 replay_v_o,
  output logic [fetch_pkg::pc_width_lp-1:0]    replay_pc_o,
  output logic                                 stall_o
);
  import fetch_pkg::*;

  typedef enum logic [1:0] {
    s_idle,
    s_req,
    s_write,
    s_replay
  } state_e;

  state_e                 state_r;
  state_e                 state_n;
  logic [pc_width_lp-1:0] miss_pc_r;

  // one pass per miss, no early exit
  always_comb begin
    state_n = state_r;
    case (state_r)
      s_idle:   if (miss_i) state_n = s_req;
      s_req:    state_n = s_write;
      s_write:  state_n = s_replay;
      s_replay: state_n = s_idle;
      default:  state_n = s_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= s_idle;
    end else begin
      state_r <= state_n;
    end
  end

  // missing PC captured only when idle
  always_ff @(posedge clk_i) begin
    if ((state_r == s_idle) && miss_i) begin
      miss_pc_r <= miss_pc_i;
    end
  end

  assign mem_v_o    = state_r == s_req;
  assign mem_addr_o = miss_pc_r;

  // data arrives the cycle after the request, written straight through
  assign wr_v_o = state_r == s_write;
  assign wr_o   = '{pc: miss_pc_r, instr: mem_data_i};

  assign replay_v_o  = state_r == s_replay;
  assign replay_pc_o = miss_pc_r;
  assign stall_o     = state_r != s_idle;

  // fetch is frozen while busy, no second miss may arrive
  a_no_miss_busy: assert property (
    @(posedge clk_i) disable iff (reset_i)
    stall_o |-> !miss_i
  ) else $error("icache_refill: miss arrived while refill busy");

endmodule

//--- verif/fetch_tb.sv
/* fetch_tb
   testbench for the fetch front end; a program table fills the backing
   memory, a reference walk of the static prediction rule and a tag model
   give the expected fetch stream and memory reads */
`timescale 1ns/1ps

module fetch_tb;
  import fetch_pkg::*;

  localparam int num_prog_lp     = 14;
  localparam int num_redir_lp    = 2;
  localparam int num_rows_lp     = 23;
  localparam int reset_cycles_lp = 8;
  localparam int mem_words_lp    = 1 << pc_width_lp;

  localparam logic [pc_width_lp-1:0] jalr_pred_lp = 10'h025;

  localparam logic [1:0] k_alu_lp    = 2'd0;
  localparam logic [1:0] k_branch_lp = 2'd1;
  localparam logic [1:0] k_jal_lp    = 2'd2;
  localparam logic [1:0] k_jalr_lp   = 2'd3;

  // fields the cache must not touch, bit 31 carries the immediate sign
  localparam logic [31:0] branch_keep_lp = 32'h81ff_f07f;
  localparam logic [31:0] jal_keep_lp    = 32'h8000_0fff;
  localparam logic [6:0]  op_imm_lp      = 7'b0010011;

  typedef struct packed {
    logic [pc_width_lp-1:0] pc;
    logic [1:0]             kind;
    logic [31:0]            imm;
  } prog_row_s;

  typedef struct packed {
    logic [7:0]             after_row;
    logic [pc_width_lp-1:0] target;
  } redir_row_s;

  typedef struct packed {
    logic [pc_width_lp-1:0]    pc;
    logic [instr_width_lp-1:0] instr;
    logic [1:0]                kind;
    logic [pc_width_lp-1:0]    pred;
    logic [7:0]                reads;
  } exp_row_s;

  logic                      clk_i = 1'b0;
  logic                      reset_i;
  logic                      redirect_v_i;
  logic [pc_width_lp-1:0]    redirect_pc_i;
  logic [pc_width_lp-1:0]    jalr_pred_i;
  logic                      mem_v_o;
  logic [pc_width_lp-1:0]    mem_addr_o;
  logic [instr_width_lp-1:0] mem_data_i;
  logic                      fetch_v_o;
  fetch_out_s                fetch_o;

  prog_row_s                      prog_tab [num_prog_lp];
  redir_row_s                     redir_tab [num_redir_lp];
  exp_row_s                       exp_tab [num_rows_lp];
  logic [instr_width_lp-1:0]      mem_words [mem_words_lp];
  logic [1:0]                     mem_kind [mem_words_lp];
  int                             mem_imm [mem_words_lp];
  logic [pc_width_lp-1:0]         req_q [$];
  logic [icache_tag_width_lp-1:0] tag_m [icache_entries_lp];
  logic [icache_entries_lp-1:0]   valid_m;
  int                             exp_count;
  int                             req_seen;
  int                             error_count;
  int                             rows_failed;
  int                             beat_idx;
  int                             redir_idx;
  logic                           redirect_due;
  logic                           tables_ready = 1'b0;

  fetch_top UUT (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .redirect_v_i (redirect_v_i),
    .redirect_pc_i(redirect_pc_i),
    .jalr_pred_i  (jalr_pred_i),
    .mem_v_o      (mem_v_o),
    .mem_addr_o   (mem_addr_o),
    .mem_data_i   (mem_data_i),
    .fetch_v_o    (fetch_v_o),
    .fetch_o      (fetch_o)
  );

  always #10 clk_i = ~clk_i;

  // backing memory, data one cycle after the strobe
  always @(posedge clk_i) begin
    if (mem_v_o) begin
      mem_data_i <= mem_words[mem_addr_o];
    end
  end

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // small assembler, beq x1,x2 / jal x1 / jalr x0,x1 / addi x5,x5
  function automatic logic [31:0] encode(input logic [1:0] kind, input int imm);
    logic [31:0] i;
    i = imm;
    case (kind)
      k_branch_lp: return {i[12], i[10:5], 5'd2, 5'd1, 3'b000, i[4:1], i[11], op_branch_lp};
      k_jal_lp:    return {i[20], i[10:1], i[11], i[19:12], 5'd1, op_jal_lp};
      k_jalr_lp:   return {12'h000, 5'd1, 3'b000, 5'd0, op_jalr_lp};
      default:     return {i[11:0], 5'd5, 3'b000, 5'd5, op_imm_lp};
    endcase
  endfunction

  // full 32-bit byte arithmetic, then cut to the word PC
  function automatic logic [pc_width_lp-1:0] target_of(
    input logic [pc_width_lp-1:0] pc,
    input int                     imm
  );
    logic [31:0] byte_addr;
    byte_addr = 32'({pc, 2'b00}) + imm;
    return byte_addr[pc_width_lp+1:2];
  endfunction

  function automatic logic [pc_width_lp-1:0] pred_of(input logic [pc_width_lp-1:0] pc);
    case (mem_kind[pc])
      k_branch_lp, k_jal_lp: return target_of(pc, mem_imm[pc]);
      k_jalr_lp:             return jalr_pred_lp;
      default:               return '0;
    endcase
  endfunction

  // static rule: jumps and backward branches taken
  function automatic logic [pc_width_lp-1:0] next_pc_of(input logic [pc_width_lp-1:0] pc);
    case (mem_kind[pc])
      k_jal_lp, k_jalr_lp: return pred_of(pc);
      k_branch_lp:         return (mem_imm[pc] < 0) ? pred_of(pc) : pc + 1'b1;
      default:             return pc + 1'b1;
    endcase
  endfunction

  function automatic logic [31:0] keep_mask(input logic [1:0] kind);
    case (kind)
      k_branch_lp: return branch_keep_lp;
      k_jal_lp:    return jal_keep_lp;
      default:     return '1;
    endcase
  endfunction

  task automatic load_tables();
    // carry cases: 0x003 no borrow, 0x025 borrow below 0, 0x3f1/0x3f2 wrap past top
    prog_tab[0]  = '{pc: 10'h000, kind: k_alu_lp,    imm: 1};
    prog_tab[1]  = '{pc: 10'h001, kind: k_alu_lp,    imm: 2};
    prog_tab[2]  = '{pc: 10'h002, kind: k_branch_lp, imm: 16};
    prog_tab[3]  = '{pc: 10'h003, kind: k_branch_lp, imm: -12};
    prog_tab[4]  = '{pc: 10'h3f0, kind: k_alu_lp,    imm: 3};
    prog_tab[5]  = '{pc: 10'h3f1, kind: k_branch_lp, imm: 'h100};
    prog_tab[6]  = '{pc: 10'h3f2, kind: k_jal_lp,    imm: 'h78};
    prog_tab[7]  = '{pc: 10'h010, kind: k_jalr_lp,   imm: 0};
    prog_tab[8]  = '{pc: 10'h025, kind: k_branch_lp, imm: -'h100};
    prog_tab[9]  = '{pc: 10'h3e5, kind: k_alu_lp,    imm: 4};
    prog_tab[10] = '{pc: 10'h3e6, kind: k_jal_lp,    imm: -'hf84};
    prog_tab[11] = '{pc: 10'h005, kind: k_alu_lp,    imm: 5};
    prog_tab[12] = '{pc: 10'h006, kind: k_jal_lp,    imm: 'h3c};
    // same index as 0x005, the two evict each other
    prog_tab[13] = '{pc: 10'h015, kind: k_jal_lp,    imm: -'h40};
    // first breaks the 0..3 loop on a hit, second lands on a miss
    redir_tab[0] = '{after_row: 8'd5,  target: 10'h3f0};
    redir_tab[1] = '{after_row: 8'd18, target: 10'h040};
  endtask

  task automatic fill_memory();
    logic [31:0] lfsr;
    logic [24:0] bits;
    lfsr = 32'hd983_9cbc;
    for (int a = 0; a < mem_words_lp; a++) begin
      bits = '0;
      for (int b = 0; b < 25; b++) begin
        lfsr = lfsr_step(lfsr);
        bits = {bits[23:0], lfsr[0]};
      end
      // filler is always OP-IMM, address folded in
      mem_words[a] = {bits ^ 25'(a), op_imm_lp};
      mem_kind[a]  = k_alu_lp;
      mem_imm[a]   = 0;
    end
    for (int p = 0; p < num_prog_lp; p++) begin
      mem_words[prog_tab[p].pc] = encode(prog_tab[p].kind, int'(prog_tab[p].imm));
      mem_kind[prog_tab[p].pc]  = prog_tab[p].kind;
      mem_imm[prog_tab[p].pc]   = int'(prog_tab[p].imm);
    end
  endtask

  // tag model, every miss costs one backing read
  function automatic logic model_hit(input logic [pc_width_lp-1:0] pc);
    return valid_m[pc[icache_addr_width_lp-1:0]] &&
           tag_m[pc[icache_addr_width_lp-1:0]] == pc[pc_width_lp-1:icache_addr_width_lp];
  endfunction

  task automatic model_fill(input logic [pc_width_lp-1:0] pc);
    req_q.push_back(pc);
    valid_m[pc[icache_addr_width_lp-1:0]] = 1'b1;
    tag_m[pc[icache_addr_width_lp-1:0]]   = pc[pc_width_lp-1:icache_addr_width_lp];
  endtask

  task automatic add_row(input logic [pc_width_lp-1:0] pc);
    if (!model_hit(pc)) begin
      model_fill(pc);
    end
    exp_tab[exp_count] = '{pc: pc, instr: mem_words[pc], kind: mem_kind[pc],
                           pred: pred_of(pc), reads: 8'(req_q.size())};
    exp_count++;
  endtask

  task automatic build_expected();
    logic [pc_width_lp-1:0] pc;
    logic [pc_width_lp-1:0] nxt;
    int                     r;
    pc        = '0;
    r         = 0;
    valid_m   = '0;
    exp_count = 0;
    while (exp_count < num_rows_lp) begin
      add_row(pc);
      nxt = next_pc_of(pc);
      if (r < num_redir_lp && redir_tab[r].after_row == exp_count - 1) begin
        // word already in flight still shows on a hit, a miss only refills
        if (model_hit(nxt)) begin
          if (exp_count < num_rows_lp) begin
            add_row(nxt);
          end
        end else begin
          model_fill(nxt);
        end
        nxt = redir_tab[r].target;
        r++;
      end
      pc = nxt;
    end
  endtask

  task automatic report_mismatch(
    input string       what,
    input int          row,
    input logic [31:0] got,
    input logic [31:0] exp
  );
    $display("** Error @ %0t: row %0d %s is %h, expected %h", $time, row, what, got, exp);
    error_count++;
  endtask

  task automatic check_mem_read();
    if (mem_v_o) begin
      if (req_seen < req_q.size()) begin
        assert (mem_addr_o == req_q[req_seen])
          else report_mismatch("read address", req_seen, 32'(mem_addr_o), 32'(req_q[req_seen]));
      end else begin
        $display("memory read at %h came after all expected reads", mem_addr_o);
        error_count++;
      end
      req_seen++;
    end
  endtask

  task automatic check_beat(input int i);
    exp_row_s    e;
    logic [31:0] m;
    int          errs_before;
    e           = exp_tab[i];
    m           = keep_mask(e.kind);
    errs_before = error_count;
    assert (fetch_o.pc == e.pc)
      else report_mismatch("pc", i, 32'(fetch_o.pc), 32'(e.pc));
    assert ((fetch_o.instr & m) == (e.instr & m))
      else report_mismatch("instr", i, fetch_o.instr & m, e.instr & m);
    // plain ops leave the target don't care
    if (e.kind != k_alu_lp) begin
      assert (fetch_o.pred_addr == e.pred)
        else report_mismatch("pred_addr", i, 32'(fetch_o.pred_addr), 32'(e.pred));
    end
    assert (req_seen == int'(e.reads))
      else report_mismatch("memory read count", i, 32'(req_seen), 32'(e.reads));
    if (error_count != errs_before) begin
      rows_failed++;
    end
    $display("row %0d pc %h: %s", i, e.pc, (error_count == errs_before) ? "ok" : "mismatch");
  endtask

  initial begin : main
    reset_i       = 1'b1;
    redirect_v_i  = 1'b0;
    redirect_pc_i = '0;
    jalr_pred_i   = jalr_pred_lp;
    mem_data_i    = '0;
    req_seen      = 0;
    error_count   = 0;
    rows_failed   = 0;
    beat_idx      = 0;
    redir_idx     = 0;
    redirect_due  = 1'b0;
    load_tables();
    fill_memory();
    build_expected();
    tables_ready = 1'b1;
    repeat (reset_cycles_lp) @(posedge clk_i);
    reset_i <= 1'b0;
    while (beat_idx < num_rows_lp) begin
      // outputs settle between edges
      @(negedge clk_i);
      check_mem_read();
      if (fetch_v_o) begin
        check_beat(beat_idx);
        if (redir_idx < num_redir_lp && redir_tab[redir_idx].after_row == beat_idx) begin
          redirect_due = 1'b1;
        end
        beat_idx++;
      end
      @(posedge clk_i);
      redirect_v_i <= redirect_due;
      if (redirect_due) begin
        redirect_pc_i <= redir_tab[redir_idx].target;
        redir_idx++;
      end
      redirect_due = 1'b0;
    end
    $display("rows %0d, rows with errors %0d, memory reads %0d, errors %0d",
             beat_idx, rows_failed, req_seen, error_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  // a miss costs about six cycles, ten per row leaves margin
  initial begin : watchdog
    wait (tables_ready);
    repeat (reset_cycles_lp + num_rows_lp * 10) @(posedge clk_i);
    $display("watchdog expired with %0d of %0d fetch rows seen", beat_idx, num_rows_lp);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule
